//--- Bender.yml
package:
  name: ddr_read_cfg

sources:
  - files:
      - source/ddr_read_pkg.sv
      - source/job_port.sv
      - source/ins_accept.sv
      - source/ins_dispatch.sv
      - source/ddr_read_cfg.sv
  - target: test
    files:
      - tests/ddr_read_cfg_assertions.sv
      - tests/ddr_read_cfg_tb.sv

//--- ddr_read_cfg.f
source/ddr_read_pkg.sv
source/job_port.sv
source/ins_accept.sv
source/ins_dispatch.sv
source/ddr_read_cfg.sv
tests/ddr_read_cfg_assertions.sv
tests/ddr_read_cfg_tb.sv

//--- source/ddr_read_cfg.sv
`timescale 1ns/10ps

module ddr_read_cfg #(
    parameter int PE_NUM = 32
) (
    input  logic                         clk,
    input  logic                         rst,

    // instruction intake
    input  logic                         ins_req,
    output logic                         ins_ack,
    input  ddr_read_pkg::ins_word_t      ins,
    input  ddr_read_pkg::layer_cfg_t     layer,

    // data buffer job
    output logic                         dbuf_req,
    input  logic                         dbuf_ack,
    output ddr_read_pkg::dbuf_cfg_t      dbuf_cfg,

    // weight buffer job
    output logic                         ibuf_req,
    input  logic                         ibuf_ack,
    output ddr_read_pkg::ibuf_cfg_head_t ibuf_cfg,
    output logic [PE_NUM-1:0]            ibuf_mask,

    // DDR read channels
    output logic                         ddr1_req,
    input  logic                         ddr1_ack,
    output ddr_read_pkg::burst_cmd_t     ddr1_cmd,
    output logic                         ddr2_req,
    input  logic                         ddr2_ack,
    output ddr_read_pkg::burst_cmd_t     ddr2_cmd,
    output ddr_read_pkg::ddr2_owner_t    ddr2_owner
);

    wire [ddr_read_pkg::JOB_NUM-1:0] jobs_idle;

    logic                    issue;
    ddr_read_pkg::ins_word_t held_ins;

    logic dbuf_start;
    logic ibuf_start;
    logic ddr1_start;
    logic ddr2_start;

// ======================================================================
// intake and decode
// ======================================================================

    ins_accept u_ins_accept (
        .clk       (clk),
        .rst       (rst),
        .ins_req   (ins_req),
        .ins_ack   (ins_ack),
        .ins       (ins),
        .jobs_idle (jobs_idle),
        .issue     (issue),
        .held_ins  (held_ins)
    );

    ins_dispatch #(
        .PE_NUM (PE_NUM)
    ) u_ins_dispatch (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .held_ins   (held_ins),
        .layer      (layer),
        .dbuf_start (dbuf_start),
        .ibuf_start (ibuf_start),
        .ddr1_start (ddr1_start),
        .ddr2_start (ddr2_start),
        .dbuf_cfg   (dbuf_cfg),
        .ibuf_cfg   (ibuf_cfg),
        .ibuf_mask  (ibuf_mask),
        .ddr1_cmd   (ddr1_cmd),
        .ddr2_cmd   (ddr2_cmd),
        .ddr2_owner (ddr2_owner)
    );

// ======================================================================
// job ports
// ======================================================================

    job_port dbuf_port (
        .clk   (clk),
        .rst   (rst),
        .start (dbuf_start),
        .ack   (dbuf_ack),
        .req   (dbuf_req),
        .idle  (jobs_idle[ddr_read_pkg::JOB_DBUF])
    );

    job_port ibuf_port (
        .clk   (clk),
        .rst   (rst),
        .start (ibuf_start),
        .ack   (ibuf_ack),
        .req   (ibuf_req),
        .idle  (jobs_idle[ddr_read_pkg::JOB_IBUF])
    );

    job_port ddr1_port (
        .clk   (clk),
        .rst   (rst),
        .start (ddr1_start),
        .ack   (ddr1_ack),
        .req   (ddr1_req),
        .idle  (jobs_idle[ddr_read_pkg::JOB_DDR1])
    );

    job_port ddr2_port (
        .clk   (clk),
        .rst   (rst),
        .start (ddr2_start),
        .ack   (ddr2_ack),
        .req   (ddr2_req),
        .idle  (jobs_idle[ddr_read_pkg::JOB_DDR2])
    );

endmodule

//--- source/ddr_read_pkg.sv
package ddr_read_pkg;

// ======================================================================
// widths
// ======================================================================

    localparam int INST_W        = 62;
    localparam int DDR_ADDR_W    = 32;
    localparam int BURST_W       = 16;

    // 32 bytes per pixel-channel unit
    localparam int BEAT_SHIFT    = 5;
    // burst multiplier for the triple weight read
    localparam int LINEAR_TRIPLE = 3;

    // whatever is left of the instruction word after the named fields
    localparam int SPARE_W = INST_W - 4 - 6 - 4 - 4 - 8 - DDR_ADDR_W;

    // job ports, bit positions in the idle vector
    localparam int JOB_NUM  = 4;
    localparam int JOB_DBUF = 0;
    localparam int JOB_IBUF = 1;
    localparam int JOB_DDR1 = 2;
    localparam int JOB_DDR2 = 3;

// ======================================================================
// opcodes
// ======================================================================

    typedef enum logic [3:0] {
        RD_OP_D   = 4'b0000,    // tile read, channel 1 into dbuf
        RD_OP_G   = 4'b0001,    // tile read, both channels into dbuf
        RD_OP_DW  = 4'b0100,    // linear read, channel 2 into ibuf
        RD_OP_DW3 = 4'b0110     // same with triple length
    } rd_opcode_t;

    typedef enum logic {
        OWNER_DBUF = 1'b0,
        OWNER_IBUF = 1'b1
    } ddr2_owner_t;

// ======================================================================
// instruction and layer
// ======================================================================

    // same bit positions for every opcode
    typedef struct packed {
        logic [3:0]            opcode;
        logic [5:0]            buf_id;
        logic [SPARE_W-1:0]    spare;
        logic [3:0]            row_num;
        logic [3:0]            pix_num;
        logic [7:0]            size;
        logic [DDR_ADDR_W-1:0] st_addr;
    } ins_word_t;

    typedef struct packed {
        logic [3:0] layer_type;
        logic [7:0] image_width;
        logic [3:0] in_ch_seg;
    } layer_cfg_t;

// ======================================================================
// job payloads
// ======================================================================

    typedef struct packed {
        logic [DDR_ADDR_W-1:0] st_addr;
        logic [BURST_W-1:0]    burst;
        logic [DDR_ADDR_W-1:0] step;
        logic [BURST_W-1:0]    burst_num;
    } burst_cmd_t;

    typedef struct packed {
        logic [3:0] mode;
        logic [3:0] ch_num;
        logic [3:0] row_num;
        logic [3:0] pix_num;
        logic       dual;
    } dbuf_cfg_t;

    // fixed part only, the PE mask travels beside it
    typedef struct packed {
        logic [3:0] mode;
        logic [7:0] idx_num;
    } ibuf_cfg_head_t;

endpackage

//--- source/ins_accept.sv
`timescale 1ns/10ps

module ins_accept (
    input  logic                               clk,
    input  logic                               rst,

    input  logic                               ins_req,
    output logic                               ins_ack,
    input  ddr_read_pkg::ins_word_t            ins,

    input  logic [ddr_read_pkg::JOB_NUM-1:0]   jobs_idle,

    output logic                               issue,
    output ddr_read_pkg::ins_word_t            held_ins
);

    logic                    all_idle;
    logic                    accept;
    ddr_read_pkg::ins_word_t hold_q;

// ======================================================================
// intake handshake
// ======================================================================

    // previous instruction finished only when every port is back idle
    assign all_idle = &jobs_idle;

    // new request, old one fully closed, nothing in flight
    assign accept = ins_req && !ins_ack && all_idle;

    assign issue = accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            ins_ack <= 1'b0;
        end else if (accept) begin
            ins_ack <= 1'b1;
        end else if (ins_ack && !ins_req) begin
            ins_ack <= 1'b0;
        end
    end

// ======================================================================
// instruction hold
// ======================================================================

    // ins is only guaranteed stable while req is up and unacknowledged
    always_ff @(posedge clk) begin
        if (accept) begin
            hold_q <= ins;
        end
    end

    // live word on the accepting cycle, held copy afterwards
    always_comb begin
        if (accept) begin
            held_ins = ins;
        end else begin
            held_ins = hold_q;
        end
    end

endmodule

//--- source/ins_dispatch.sv
`timescale 1ns/10ps

module ins_dispatch #(
    parameter int PE_NUM = 32
) (
    input  logic                         clk,
    input  logic                         rst,

    input  logic                         issue,
    input  ddr_read_pkg::ins_word_t      held_ins,
    input  ddr_read_pkg::layer_cfg_t     layer,

    output logic                         dbuf_start,
    output logic                         ibuf_start,
    output logic                         ddr1_start,
    output logic                         ddr2_start,

    output ddr_read_pkg::dbuf_cfg_t      dbuf_cfg,
    output ddr_read_pkg::ibuf_cfg_head_t ibuf_cfg,
    output logic [PE_NUM-1:0]            ibuf_mask,
    output ddr_read_pkg::burst_cmd_t     ddr1_cmd,
    output ddr_read_pkg::burst_cmd_t     ddr2_cmd,
    output ddr_read_pkg::ddr2_owner_t    ddr2_owner
);

    localparam int BURST_W    = ddr_read_pkg::BURST_W;
    localparam int DDR_ADDR_W = ddr_read_pkg::DDR_ADDR_W;

    localparam logic [PE_NUM-1:0] MASK_ONE  = PE_NUM'(1);
    localparam logic [PE_NUM-1:0] MASK_QUAD = PE_NUM'(4'hf);

    typedef struct packed {
        ddr_read_pkg::ibuf_cfg_head_t head;
        logic [PE_NUM-1:0]            mask;
    } ibuf_cfg_t;

    logic                     is_tile;
    logic                     is_dual;
    logic                     is_lin;
    logic                     is_triple;

    logic [BURST_W-1:0]       pix_cnt;
    logic [DDR_ADDR_W-1:0]    pix_cnt_wide;
    logic [BURST_W-1:0]       size_ext;
    logic [PE_NUM-1:0]        mask_next;

    ddr_read_pkg::burst_cmd_t tile_cmd;
    ddr_read_pkg::burst_cmd_t lin_cmd;
    ibuf_cfg_t                ibuf_q;

// ======================================================================
// opcode decode
// ======================================================================

    assign is_dual   = (held_ins.opcode == ddr_read_pkg::RD_OP_G);
    assign is_tile   = (held_ins.opcode == ddr_read_pkg::RD_OP_D) || is_dual;
    assign is_triple = (held_ins.opcode == ddr_read_pkg::RD_OP_DW3);
    assign is_lin    = (held_ins.opcode == ddr_read_pkg::RD_OP_DW) || is_triple;

    // unknown opcodes fall through with no start at all
    assign dbuf_start = issue && is_tile;
    assign ddr1_start = issue && is_tile;
    assign ibuf_start = issue && is_lin;
    assign ddr2_start = issue && (is_dual || is_lin);

// ======================================================================
// burst arithmetic
// ======================================================================

    assign pix_cnt      = BURST_W'(held_ins.pix_num) + 1'b1;
    assign pix_cnt_wide = DDR_ADDR_W'(held_ins.pix_num) + 1'b1;
    assign size_ext     = BURST_W'(held_ins.size);

    // tile read, one row of pixels per burst, stride of a full image row
    always_comb begin
        tile_cmd.st_addr   = held_ins.st_addr;
        tile_cmd.burst     = (pix_cnt * BURST_W'(layer.in_ch_seg))
                             << ddr_read_pkg::BEAT_SHIFT;
        tile_cmd.step      = (pix_cnt_wide * DDR_ADDR_W'(layer.image_width))
                             << ddr_read_pkg::BEAT_SHIFT;
        tile_cmd.burst_num = BURST_W'(held_ins.row_num);
    end

    // linear read, single burst
    always_comb begin
        lin_cmd.st_addr   = held_ins.st_addr;
        lin_cmd.burst     = is_triple ? size_ext * BURST_W'(ddr_read_pkg::LINEAR_TRIPLE)
                                      : size_ext;
        lin_cmd.step      = '0;
        lin_cmd.burst_num = '0;
    end

    // single PE or a group of four, bits past PE_NUM drop off
    assign mask_next = layer.layer_type[0] ? (MASK_ONE << held_ins.buf_id)
                                           : (MASK_QUAD << {held_ins.buf_id, 2'b00});

// ======================================================================
// payload registers
// ======================================================================

    always_ff @(posedge clk) begin
        if (dbuf_start) begin
            dbuf_cfg.mode    <= layer.layer_type;
            dbuf_cfg.ch_num  <= held_ins.size[3:0];
            dbuf_cfg.row_num <= held_ins.row_num;
            dbuf_cfg.pix_num <= held_ins.pix_num;
            dbuf_cfg.dual    <= is_dual;
        end
    end

    always_ff @(posedge clk) begin
        if (ibuf_start) begin
            ibuf_q.head.mode    <= layer.layer_type;
            ibuf_q.head.idx_num <= held_ins.size;
            ibuf_q.mask         <= mask_next;
        end
    end

    assign ibuf_cfg  = ibuf_q.head;
    assign ibuf_mask = ibuf_q.mask;

    always_ff @(posedge clk) begin
        if (ddr1_start) begin
            ddr1_cmd <= tile_cmd;
        end
    end

    // channel 2 carries the second tile half or the weight read
    always_ff @(posedge clk) begin
        if (ddr2_start) begin
            ddr2_cmd <= is_lin ? lin_cmd : tile_cmd;
        end
    end

    // read-return path of channel 2
    always_ff @(posedge clk) begin
        if (rst) begin
            ddr2_owner <= ddr_read_pkg::OWNER_DBUF;
        end else if (ddr2_start) begin
            ddr2_owner <= is_lin ? ddr_read_pkg::OWNER_IBUF : ddr_read_pkg::OWNER_DBUF;
        end
    end

endmodule

//--- source/job_port.sv
`timescale 1ns/10ps

module job_port (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic ack,
    output logic req,
    output logic idle
);

    typedef enum logic [1:0] {
        S_IDLE = 2'b00,
        S_REQ  = 2'b01,
        S_DROP = 2'b10
    } state_t;

    state_t state;

// ======================================================================
// four-phase sequencer
// ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_REQ;
                    end
                end
                // hold req until the consumer reports done
                S_REQ: begin
                    if (ack) begin
                        state <= S_DROP;
                    end
                end
                // req is down, wait for ack to return low
                S_DROP: begin
                    if (!ack) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign req  = (state == S_REQ);
    assign idle = (state == S_IDLE);

endmodule

//--- tests/ddr_read_cfg_assertions.sv
`timescale 1ns/10ps

// four-phase checks, one copy per job port and one on the intake
module ddr_read_cfg_assertions (
    input logic clk,
    input logic rst,
    input logic hold,
    input logic done,
    input logic allow
);

    int fail_cnt = 0;

    // an open handshake stays up until its partner lets go
    hold_until_done: assert property (
        @(posedge clk) disable iff (rst) hold && !done |=> hold
    ) else begin
        $error("handshake dropped before its partner let go");
        fail_cnt++;
    end

    // req only after start, ins_ack only with every port idle
    rise_allowed: assert property (
        @(posedge clk) disable iff (rst) $rose(hold) |-> $past(allow)
    ) else begin
        $error("handshake rose without permission");
        fail_cnt++;
    end

    low_after_reset: assert property (
        @(posedge clk) rst |=> !hold
    ) else begin
        $error("handshake high in the cycle after reset");
        fail_cnt++;
    end

endmodule

bind job_port ddr_read_cfg_assertions job_port_checks (
    .clk   (clk),
    .rst   (rst),
    .hold  (req),
    .done  (ack),
    .allow (start)
);

bind ins_accept ddr_read_cfg_assertions intake_checks (
    .clk   (clk),
    .rst   (rst),
    .hold  (ins_ack),
    .done  (!ins_req),
    .allow (&jobs_idle)
);

//--- tests/ddr_read_cfg_tb.sv
`timescale 1ns/10ps

module ddr_read_cfg_tb;

    localparam int PE_NUM = 32;
    // cycles allowed for any single wait
    localparam int LIMIT  = 100;

    typedef ddr_read_pkg::ins_word_t  ins_word_t;
    typedef ddr_read_pkg::layer_cfg_t layer_cfg_t;

    // jobs bits follow the package JOB_* positions
    typedef struct packed {
        logic [3:0]                   jobs;
        ddr_read_pkg::dbuf_cfg_t      dbuf;
        ddr_read_pkg::ibuf_cfg_head_t ibuf;
        logic [PE_NUM-1:0]            mask;
        ddr_read_pkg::burst_cmd_t     ddr1;
        ddr_read_pkg::burst_cmd_t     ddr2;
        ddr_read_pkg::ddr2_owner_t    owner;
    } expect_t;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         ins_req;
    logic                         ins_ack;
    ins_word_t                    ins;
    layer_cfg_t                   layer;
    logic                         dbuf_req;
    ddr_read_pkg::dbuf_cfg_t      dbuf_cfg;
    logic                         ibuf_req;
    ddr_read_pkg::ibuf_cfg_head_t ibuf_cfg;
    logic [PE_NUM-1:0]            ibuf_mask;
    logic                         ddr1_req;
    ddr_read_pkg::burst_cmd_t     ddr1_cmd;
    logic                         ddr2_req;
    ddr_read_pkg::burst_cmd_t     ddr2_cmd;
    ddr_read_pkg::ddr2_owner_t    ddr2_owner;

    logic [3:0] acks  = '0;
    logic [3:0] stall = '0;
    logic [3:0] prev_reqs;
    logic       prev_ack;
    int         wait_cnt [4];
    int         delay [4];
    expect_t    exp_cur;
    int         err_cnt     = 0;
    int         timeout_cnt = 0;

    wire [3:0] reqs     = {ddr2_req, ddr1_req, ibuf_req, dbuf_req};
    wire       dbuf_ack = acks[ddr_read_pkg::JOB_DBUF];
    wire       ibuf_ack = acks[ddr_read_pkg::JOB_IBUF];
    wire       ddr1_ack = acks[ddr_read_pkg::JOB_DDR1];
    wire       ddr2_ack = acks[ddr_read_pkg::JOB_DDR2];

    ddr_read_cfg #(.PE_NUM(PE_NUM)) DUT (.*);

    always #5 clk = ~clk;

// ======================================================================
// job consumers
// ======================================================================

    // ack after 1 to 8 cycles, held off while stalled
    always @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (rst) begin
                acks[i]     <= 1'b0;
                wait_cnt[i] <= 0;
                delay[i]    <= 1 + ($urandom % 8);
            end else if (reqs[i] && !acks[i]) begin
                if (wait_cnt[i] + 1 >= delay[i] && !stall[i]) begin
                    acks[i]     <= 1'b1;
                    wait_cnt[i] <= 0;
                    delay[i]    <= 1 + ($urandom % 8);
                end else begin
                    wait_cnt[i] <= wait_cnt[i] + 1;
                end
            end else if (!reqs[i]) begin
                acks[i] <= 1'b0;
            end
        end
    end

// ======================================================================
// reference model and compare
// ======================================================================

    function automatic expect_t ref_jobs(input ins_word_t w, input layer_cfg_t l);
        expect_t e;
        int      pix;
        int      sz;
        logic    lin;
        pix = w.pix_num + 1;
        sz  = w.size;
        lin = (w.opcode == ddr_read_pkg::RD_OP_DW) || (w.opcode == ddr_read_pkg::RD_OP_DW3);
        e   = '0;
        case (w.opcode)
            ddr_read_pkg::RD_OP_D:   e.jobs = 4'b0101;
            ddr_read_pkg::RD_OP_G:   e.jobs = 4'b1101;
            ddr_read_pkg::RD_OP_DW,
            ddr_read_pkg::RD_OP_DW3: e.jobs = 4'b1010;
            default:                 e.jobs = 4'b0000;
        endcase
        e.dbuf = '{mode: l.layer_type, ch_num: w.size[3:0], row_num: w.row_num,
                   pix_num: w.pix_num, dual: (w.opcode == ddr_read_pkg::RD_OP_G)};
        e.ibuf = '{mode: l.layer_type, idx_num: w.size};
        // one PE, or the group of four that buf_id names
        for (int b = 0; b < PE_NUM; b++) begin
            e.mask[b] = l.layer_type[0] ? (b == w.buf_id) : (b / 4 == w.buf_id);
        end
        e.ddr1 = '{st_addr: w.st_addr, burst: 16'(pix * l.in_ch_seg * 32),
                   step: 32'(pix * l.image_width * 32), burst_num: 16'(w.row_num)};
        if (lin) begin
            if (w.opcode == ddr_read_pkg::RD_OP_DW3) begin
                sz = sz * 3;
            end
            e.ddr2  = '{st_addr: w.st_addr, burst: 16'(sz), step: '0, burst_num: '0};
            e.owner = ddr_read_pkg::OWNER_IBUF;
        end else begin
            e.ddr2  = e.ddr1;
            e.owner = ddr_read_pkg::OWNER_DBUF;
        end
        return e;
    endfunction

    always @(negedge clk) begin
        logic [3:0] rose;
        rose = reqs & ~prev_reqs;
        if (rst) begin
            prev_reqs <= '0;
            prev_ack  <= 1'b0;
        end else begin
            // jobs start together with ins_ack and never on their own
            if (ins_ack && !prev_ack) begin
                assert (reqs == exp_cur.jobs)
                    else log_mismatch($sformatf("jobs %b, expected %b", reqs, exp_cur.jobs));
            end else begin
                assert (rose == '0)
                    else log_mismatch($sformatf("jobs %b started with no instruction", rose));
            end
            if (rose[ddr_read_pkg::JOB_DBUF]) begin
                assert (dbuf_cfg == exp_cur.dbuf)
                    else log_mismatch($sformatf("dbuf_cfg %h, expected %h", dbuf_cfg,
                                                exp_cur.dbuf));
            end
            if (rose[ddr_read_pkg::JOB_IBUF]) begin
                assert (ibuf_cfg == exp_cur.ibuf && ibuf_mask == exp_cur.mask)
                    else log_mismatch($sformatf("ibuf %h mask %h, expected %h mask %h",
                                                ibuf_cfg, ibuf_mask, exp_cur.ibuf, exp_cur.mask));
            end
            if (rose[ddr_read_pkg::JOB_DDR1]) begin
                assert (ddr1_cmd == exp_cur.ddr1)
                    else log_mismatch($sformatf("ddr1_cmd %h, expected %h", ddr1_cmd,
                                                exp_cur.ddr1));
            end
            if (rose[ddr_read_pkg::JOB_DDR2]) begin
                assert (ddr2_cmd == exp_cur.ddr2 && ddr2_owner == exp_cur.owner)
                    else log_mismatch($sformatf("ddr2_cmd %h owner %0d, expected %h owner %0d",
                                                ddr2_cmd, ddr2_owner, exp_cur.ddr2, exp_cur.owner));
            end
            prev_reqs <= reqs;
            prev_ack  <= ins_ack;
        end
    end

// ======================================================================
// helpers
// ======================================================================

    task automatic log_mismatch(input string msg);
        err_cnt++;
        $display("error %0t: %s", $time, msg);
    endtask

    task automatic end_run();
        int sva_cnt;
        sva_cnt = DUT.u_ins_accept.intake_checks.fail_cnt
                + DUT.dbuf_port.job_port_checks.fail_cnt
                + DUT.ibuf_port.job_port_checks.fail_cnt
                + DUT.ddr1_port.job_port_checks.fail_cnt
                + DUT.ddr2_port.job_port_checks.fail_cnt;
        $display("%0d value errors, %0d assertion failures, %0d timeouts",
                 err_cnt, sva_cnt, timeout_cnt);
        if (err_cnt == 0 && sva_cnt == 0 && timeout_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        timeout_cnt++;
        $display("timed out at %0t waiting for %s", $time, what);
        end_run();
    endtask

    function automatic ins_word_t make_ins(input logic [3:0] op, input logic [5:0] id,
                                           input logic [3:0] row, input logic [3:0] pix,
                                           input logic [7:0] size, input logic [31:0] addr);
        return '{opcode: op, buf_id: id, spare: '0, row_num: row, pix_num: pix,
                 size: size, st_addr: addr};
    endfunction

    task automatic raise_ins(input ins_word_t w, input layer_cfg_t l);
        @(posedge clk);
        exp_cur = ref_jobs(w, l);
        ins     <= w;
        layer   <= l;
        ins_req <= 1'b1;
    endtask

    task automatic complete_ins();
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!ins_ack && t < LIMIT);
        if (!ins_ack) begin
            give_up("ins_ack to rise");
        end
        @(posedge clk);
        ins_req <= 1'b0;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (ins_ack && t < LIMIT);
        if (ins_ack) begin
            give_up("ins_ack to fall");
        end
    endtask

    task automatic send_ins(input ins_word_t w, input layer_cfg_t l);
        raise_ins(w, l);
        complete_ins();
    endtask

// ======================================================================
// stimulus
// ======================================================================

    initial begin
        ins_word_t  w;
        layer_cfg_t l;
        int         t;
        void'($urandom(40));
        rst     = 1'b1;
        ins_req = 1'b0;
        ins     = '0;
        layer   = '0;
        exp_cur = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // channel 2 return path belongs to dbuf out of reset
        @(negedge clk);
        assert (ddr2_owner == ddr_read_pkg::OWNER_DBUF)
            else log_mismatch("ddr2_owner is not OWNER_DBUF after reset");

        // tile reads, one channel then both
        l = '{layer_type: 4'h2, image_width: 8'd56, in_ch_seg: 4'd4};
        send_ins(make_ins(ddr_read_pkg::RD_OP_D, 6'd3, 4'd5, 4'd3, 8'h2a, 32'h1000_0040), l);
        send_ins(make_ins(ddr_read_pkg::RD_OP_G, 6'd1, 4'd7, 4'd15, 8'h13, 32'h2000_0000), l);

        // weight reads, single PE masks then groups of four
        l.layer_type = 4'h5;
        send_ins(make_ins(ddr_read_pkg::RD_OP_DW, 6'd5, 4'd0, 4'd0, 8'd200, 32'h0008_0000), l);
        send_ins(make_ins(ddr_read_pkg::RD_OP_DW3, 6'd31, 4'd0, 4'd0, 8'd255, 32'h0009_0000), l);
        l.layer_type = 4'h4;
        send_ins(make_ins(ddr_read_pkg::RD_OP_DW, 6'd7, 4'd2, 4'd1, 8'd17, 32'h000a_0000), l);
        send_ins(make_ins(ddr_read_pkg::RD_OP_DW3, 6'd9, 4'd0, 4'd0, 8'd40, 32'h000b_0000), l);

        send_ins(make_ins(4'b1001, 6'd2, 4'd1, 4'd1, 8'd1, 32'h0000_0100), l);

        // ddr1 held busy, the next instruction has to wait for it
        stall[ddr_read_pkg::JOB_DDR1] = 1'b1;
        send_ins(make_ins(ddr_read_pkg::RD_OP_D, 6'd0, 4'd2, 4'd2, 8'd3, 32'h3000_0000), l);
        raise_ins(make_ins(ddr_read_pkg::RD_OP_G, 6'd0, 4'd1, 4'd4, 8'd9, 32'h3100_0000), l);
        repeat (20) begin
            @(negedge clk);
            assert (!ins_ack) else log_mismatch("ins_ack rose while ddr1 was still busy");
        end
        stall = '0;
        complete_ins();

        repeat (200) begin
            w = ins_word_t'(62'({$urandom, $urandom}));
            case ($urandom % 5)
                0:       w.opcode = ddr_read_pkg::RD_OP_D;
                1:       w.opcode = ddr_read_pkg::RD_OP_G;
                2:       w.opcode = ddr_read_pkg::RD_OP_DW;
                3:       w.opcode = ddr_read_pkg::RD_OP_DW3;
                default: w.opcode = w.opcode | 4'b1000;
            endcase
            l = layer_cfg_t'(16'($urandom));
            send_ins(w, l);
        end

        // let the last jobs close
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while ((reqs != '0 || acks != '0) && t < LIMIT);
        if (reqs != '0 || acks != '0) begin
            give_up("the job ports to go idle");
        end
        end_run();
    end

endmodule
